//--- include/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define DATA_W    32
`define REG_AW    5

`define MEM_WORDS 1024
`define MEM_AW    10                 // Word index into 4 KB

`define CTRL_ADDR 32'h0000_1000      // Bit 0 is run
`define STAT_ADDR 32'h0000_1004      // Reads the current PC

`define LINK_REG  5'd31
`define RESET_PC  32'h0000_0000

`endif

//--- src/cpuPkg.sv
`include "cpu_params.svh"

package cpuPkg;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeT;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm16;
	} iTypeT;

	typedef struct packed {
		logic [5:0] op;
		logic [25:0] target26;
	} jTypeT;

	typedef union packed {
		rTypeT r;
		iTypeT i;
		jTypeT j;
	} instrT;

	typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRA, LUI} aluOpT;
	typedef enum logic [1:0] {BYTE, HALF, WORD} sizeT;

	typedef enum logic {A_RS, A_RT} aSelT;            // A_RT also swaps the register pair
	typedef enum logic [1:0] {B_REG, B_IMM, B_SHAMT} bSelT;
	typedef enum logic [1:0] {DST_RT, DST_RD, DST_LINK} dstT;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbT;
	typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LTZ, BR_GEZ, BR_GTZ} brT;

	typedef struct packed {
		aluOpT aluOp;
		aSelT aSel;
		bSelT bSel;
		logic regWrite;
		dstT regDst;
		wbT wbSel;
		logic memRead;
		logic memWrite;
		sizeT size;
		logic loadSigned;
		logic immSigned;
		brT branch;
		logic jump;
		logic jumpReg;
	} ctrlT;

	typedef struct packed {
		logic valid;
		logic write;
		sizeT size;
		logic loadSigned;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} memReqT;

	typedef struct packed {
		logic grant;
		logic [`DATA_W-1:0] rdata;
	} memRspT;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
	} apbReqT;

	typedef struct packed {
		logic ready;
		logic [`DATA_W-1:0] rdata;
	} apbRspT;

endpackage

//--- src/ctrlDecoder.sv
`timescale 1ns/1ps

module ctrlDecoder import cpuPkg::*; (
	input  instrT instr,
	output ctrlT  ctrl
);

	always_comb begin
		ctrl = '0; // Nop with nothing written
		if (instr != '0) begin
			case (instr.r.op)
				6'd0: begin // SPECIAL
					ctrl.regWrite = 1'b1;
					ctrl.regDst = DST_RD;
					case (instr.r.funct)
						6'd32, 6'd33: ctrl.aluOp = ADD; // No overflow trap
						6'd34, 6'd35: ctrl.aluOp = SUB;
						6'd36: ctrl.aluOp = AND;
						6'd37: ctrl.aluOp = OR;
						6'd38: ctrl.aluOp = XOR;
						6'd39: ctrl.aluOp = NOR;
						6'd42: ctrl.aluOp = SLT;
						6'd43: ctrl.aluOp = SLTU;
						6'd0, 6'd3, 6'd4, 6'd7: begin // SLL SRA SLLV SRAV
							ctrl.aluOp = instr.r.funct[1] ? SRA : SLL;
							ctrl.aSel = A_RT;
							ctrl.bSel = instr.r.funct[2] ? B_REG : B_SHAMT;
						end
						6'd8: begin // JR
							ctrl.regWrite = 1'b0;
							ctrl.jumpReg = 1'b1;
						end
						default: ctrl.regWrite = 1'b0;
					endcase
				end
				6'd1: begin // REGIMM selected by rt
					if (instr.i.rt == 5'd0)
						ctrl.branch = BR_LTZ;
					else if (instr.i.rt == 5'd1)
						ctrl.branch = BR_GEZ;
				end
				6'd2: ctrl.jump = 1'b1;
				6'd3: begin // JAL
					ctrl.jump = 1'b1;
					ctrl.regWrite = 1'b1;
					ctrl.regDst = DST_LINK;
					ctrl.wbSel = WB_LINK;
				end
				6'd4, 6'd5: begin
					ctrl.aluOp = SUB;
					ctrl.branch = instr.i.op[0] ? BR_NE : BR_EQ;
				end
				6'd7: begin
					ctrl.aluOp = OR; // Zero flags rs == 0 since rt is $0
					ctrl.branch = BR_GTZ;
				end
				6'd8, 6'd9, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14, 6'd15: begin
					ctrl.regWrite = 1'b1;
					ctrl.bSel = B_IMM;
					ctrl.immSigned = !instr.i.op[2];
					case (instr.i.op[2:0])
						3'd2: ctrl.aluOp = SLT;
						3'd3: ctrl.aluOp = SLTU;
						3'd4: ctrl.aluOp = AND;
						3'd5: ctrl.aluOp = OR;
						3'd6: ctrl.aluOp = XOR;
						3'd7: ctrl.aluOp = LUI;
						default: ctrl.aluOp = ADD;
					endcase
				end
				6'd32, 6'd33, 6'd35, 6'd36, 6'd37: begin // Loads
					ctrl.regWrite = 1'b1;
					ctrl.wbSel = WB_MEM;
					ctrl.memRead = 1'b1;
					ctrl.bSel = B_IMM;
					ctrl.immSigned = 1'b1;
					ctrl.loadSigned = !instr.i.op[2];
					ctrl.size = instr.i.op[1] ? WORD : (instr.i.op[0] ? HALF : BYTE);
				end
				6'd40, 6'd41, 6'd43: begin // Stores
					ctrl.memWrite = 1'b1;
					ctrl.bSel = B_IMM;
					ctrl.immSigned = 1'b1;
					ctrl.size = instr.i.op[1] ? WORD : (instr.i.op[0] ? HALF : BYTE);
				end
				default: ctrl = '0;
			endcase
		end
	end

endmodule

//--- src/aluUnit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module aluUnit import cpuPkg::*; (
	input  aluOpT              op,
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	output logic [`DATA_W-1:0] result,
	output logic               zero
);

	// Shifts move a by the low bits of b
	always_comb begin
		case (op)
			ADD:  result = a + b;
			SUB:  result = a - b;
			AND:  result = a & b;
			OR:   result = a | b;
			XOR:  result = a ^ b;
			NOR:  result = ~(a | b);
			SLT:  result = {{(`DATA_W-1){1'b0}}, $signed(a) < $signed(b)};
			SLTU: result = {{(`DATA_W-1){1'b0}}, a < b};
			SLL:  result = a << b[4:0];
			SRA:  result = $signed(a) >>> b[4:0];
			LUI:  result = {b[15:0], 16'h0000};
			default: result = '0;
		endcase
	end

	assign zero = (result == '0); // BEQ and BNE

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module regFile (
	input  logic               clk,
	input  logic               arstN,
	input  logic [`REG_AW-1:0] ra1,
	input  logic [`REG_AW-1:0] ra2,
	output logic [`DATA_W-1:0] rd1,
	output logic [`DATA_W-1:0] rd2,
	input  logic               we,
	input  logic [`REG_AW-1:0] wa,
	input  logic [`DATA_W-1:0] wd
);

	logic [`DATA_W-1:0] regs [2**`REG_AW];

	assign rd1 = regs[ra1];
	assign rd2 = regs[ra2];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 2**`REG_AW; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin // $0 stays zero
			regs[wa] <= wd;
		end
	end

endmodule

//--- src/cpuCore.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpuCore import cpuPkg::*; (
	input  logic               clk,
	input  logic               arstN,
	input  logic               run,
	output logic [`DATA_W-1:0] fetchAddr,
	input  instrT              instr,
	output memReqT             dReq,
	input  memRspT             dRsp,
	output logic [`DATA_W-1:0] pc
);

	ctrlT ctrl;
	logic runQ;
	logic [`DATA_W-1:0] pcQ, pcNext4, pcNext, brTarget, imm;
	logic [`DATA_W-1:0] rd1, rd2, aluA, regB, aluB, aluRes, wbData;
	logic [`REG_AW-1:0] wa;
	logic zero, taken, we;

	ctrlDecoder uDec (.instr(instr), .ctrl(ctrl));

	regFile uRegs (.clk(clk), .arstN(arstN), .ra1(instr.r.rs), .ra2(instr.r.rt),
		.rd1(rd1), .rd2(rd2), .we(we), .wa(wa), .wd(wbData));

	aluUnit uAlu (.op(ctrl.aluOp), .a(aluA), .b(aluB), .result(aluRes), .zero(zero));

	assign pc = (run && !runQ) ? `RESET_PC : pcQ; // Every run starts at the vector
	assign fetchAddr = pc;
	assign pcNext4 = pc + 32'd4;
	assign brTarget = pcNext4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign imm = ctrl.immSigned ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
	                            : {16'h0000, instr.i.imm16};

	assign aluA = (ctrl.aSel == A_RT) ? rd2 : rd1;
	assign regB = (ctrl.aSel == A_RT) ? rd1 : rd2; // Other register of the pair
	assign aluB = (ctrl.bSel == B_IMM)   ? imm :
	              (ctrl.bSel == B_SHAMT) ? {27'd0, instr.r.shamt} : regB;

	always_comb begin
		case (ctrl.branch)
			BR_EQ:  taken = zero;
			BR_NE:  taken = !zero;
			BR_LTZ: taken = rd1[31];
			BR_GEZ: taken = !rd1[31];
			BR_GTZ: taken = !rd1[31] && !zero;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		if (ctrl.jumpReg)
			pcNext = rd1;
		else if (ctrl.jump)
			pcNext = {pcNext4[31:28], instr.j.target26, 2'b00};
		else if (taken)
			pcNext = brTarget;
		else
			pcNext = pcNext4;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcQ <= `RESET_PC;
			runQ <= 1'b0;
		end else begin
			runQ <= run;
			if (run)
				pcQ <= pcNext;
		end
	end

	assign wa = (ctrl.regDst == DST_LINK) ? `LINK_REG :
	            (ctrl.regDst == DST_RD)   ? instr.r.rd : instr.r.rt;
	assign wbData = (ctrl.wbSel == WB_MEM)  ? dRsp.rdata :
	                (ctrl.wbSel == WB_LINK) ? pcNext4 : aluRes;
	assign we = run & ctrl.regWrite & (!ctrl.memRead | dRsp.grant);

	assign dReq.valid = run & (ctrl.memRead | ctrl.memWrite);
	assign dReq.write = ctrl.memWrite;
	assign dReq.size = ctrl.size;
	assign dReq.loadSigned = ctrl.loadSigned;
	assign dReq.addr = aluRes;
	assign dReq.wdata = rd2;

endmodule

//--- src/apbPort.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module apbPort import cpuPkg::*; (
	input  logic               clk,
	input  logic               arstN,
	input  apbReqT             apbReq,
	output apbRspT             apbRsp,
	output memReqT             hReq,
	input  memRspT             hRsp,
	input  logic [`DATA_W-1:0] corePc,
	output logic               run
);

	logic access, ctrlHit, statHit;

	assign access = apbReq.sel & apbReq.enable;
	assign ctrlHit = (apbReq.addr == `CTRL_ADDR);
	assign statHit = (apbReq.addr == `STAT_ADDR);

	// Everything outside the two registers goes to memory as a word access
	assign hReq.valid = access & !(ctrlHit | statHit);
	assign hReq.write = apbReq.write;
	assign hReq.size = WORD;
	assign hReq.loadSigned = 1'b0;
	assign hReq.addr = apbReq.addr;
	assign hReq.wdata = apbReq.wdata;

	assign apbRsp.ready = access & (ctrlHit | statHit | hRsp.grant); // Waits out the core
	assign apbRsp.rdata = ctrlHit ? {{(`DATA_W-1){1'b0}}, run} :
	                      statHit ? corePc : hRsp.rdata;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			run <= 1'b0;
		else if (access && apbReq.write && ctrlHit)
			run <= apbReq.wdata[0];
	end

endmodule

//--- src/sharedMem.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module sharedMem import cpuPkg::*; (
	input  logic               clk,
	input  logic [`DATA_W-1:0] fetchAddr,
	output instrT              fetchData,
	input  memReqT             cReq,
	output memRspT             cRsp,
	input  memReqT             hReq,
	output memRspT             hRsp
);

	logic [`DATA_W-1:0] mem [`MEM_WORDS];
	memReqT req;
	logic [`MEM_AW-1:0] idx;
	logic [`DATA_W-1:0] word, lane, wData, ldData;
	logic [3:0] be;

	assign fetchData = mem[fetchAddr[`MEM_AW+1:2]];

	assign cRsp.grant = cReq.valid;
	assign hRsp.grant = hReq.valid & !cReq.valid; // Core has fixed priority
	assign req = cReq.valid ? cReq : hReq;
	assign idx = req.addr[`MEM_AW+1:2];
	assign word = mem[idx];
	assign lane = word >> {req.addr[1:0], 3'b000};

	always_comb begin
		case (req.size)
			BYTE: begin
				be = 4'b0001 << req.addr[1:0];
				wData = {4{req.wdata[7:0]}};
				ldData = {{24{req.loadSigned & lane[7]}}, lane[7:0]};
			end
			HALF: begin
				be = req.addr[1] ? 4'b1100 : 4'b0011;
				wData = {2{req.wdata[15:0]}};
				ldData = {{16{req.loadSigned & lane[15]}}, lane[15:0]};
			end
			default: begin
				be = 4'b1111;
				wData = req.wdata;
				ldData = word;
			end
		endcase
	end

	assign cRsp.rdata = ldData;
	assign hRsp.rdata = ldData;

	always_ff @(posedge clk) begin
		if (req.valid && req.write) begin
			for (int i = 0; i < 4; i++) begin
				if (be[i])
					mem[idx][8*i +: 8] <= wData[8*i +: 8]; // Lane merge
			end
		end
	end

endmodule

//--- src/mipsTop.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mipsTop import cpuPkg::*; (
	input  logic   clk,
	input  logic   arstN,
	input  apbReqT apbReq,
	output apbRspT apbRsp
);

	logic [`DATA_W-1:0] fetchAddr, pc;
	instrT instr;
	memReqT dReq, hReq;
	memRspT dRsp, hRsp;
	logic run;

	cpuCore uCore (.clk(clk), .arstN(arstN), .run(run), .fetchAddr(fetchAddr),
		.instr(instr), .dReq(dReq), .dRsp(dRsp), .pc(pc));

	apbPort uApb (.clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp),
		.hReq(hReq), .hRsp(hRsp), .corePc(pc), .run(run));

	sharedMem uMem (.clk(clk), .fetchAddr(fetchAddr), .fetchData(instr),
		.cReq(dReq), .cRsp(dRsp), .hReq(hReq), .hRsp(hRsp));

endmodule

//--- dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic arstN
);

	initial clk = 1'b0;
	always #4 clk = ~clk; // 8 ns period

	initial begin
		arstN = 1'b0;
		repeat (16) @(posedge clk);
		arstN <= 1'b1;
	end

endmodule

//--- dv/mipsTb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mipsTb import cpuPkg::*; ();

	localparam int NUM_TESTS = 6;
	localparam int MAX_PROG = 64;
	localparam int APB_CYC = 8;
	localparam int TIMEOUT_CYC = 5 * NUM_TESTS * MAX_PROG * APB_CYC;
	localparam logic [31:0] MARKER = 32'h0000_5A5A;

	logic clk, arstN;
	apbReqT apbReq;
	apbRspT apbRsp;
	logic [31:0] lfsrState;
	instrT prog[$];
	logic [31:0] expAddr[$];
	logic [31:0] expVal[$];
	logic [31:0] loopAddr;
	logic [31:0] slotAddr;

	tbClock uClk (.clk(clk), .arstN(arstN));

	mipsTop u_mipsTop (.clk(clk), .arstN(arstN), .apbReq(apbReq), .apbRsp(apbRsp));

	initial begin
		repeat (TIMEOUT_CYC) @(posedge clk);
		$display("Watchdog timeout, the tests did not finish in %0d cycles", TIMEOUT_CYC);
		$display("TESTS FAILED");
		$fatal(1, "Run stopped by watchdog");
	end

	function automatic logic lfsrBit();
		logic lsb;
		lsb = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (lsb)
			lfsrState = lfsrState ^ 32'hA300_0000; // x^32+x^30+x^26+x^25+1
		return lsb;
	endfunction

	function automatic logic [31:0] lfsrWord();
		logic [31:0] w;
		for (int i = 0; i < 32; i++)
			w[i] = lfsrBit();
		return w;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("TESTS FAILED");
			$fatal(1, "Check failed");
		end
	endtask

	// Setup on one edge, access on the next, sample while stable
	task automatic apbXfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		apbReqT r;
		r = '0;
		r.sel = 1'b1;
		r.write = wr;
		r.addr = addr;
		r.wdata = wdata;
		@(posedge clk);
		apbReq <= r;
		@(posedge clk);
		apbReq.enable <= 1'b1;
		do @(negedge clk); while (!apbRsp.ready);
		rdata = apbRsp.rdata;
		@(posedge clk);
		apbReq <= '0;
	endtask

	task automatic apbWrite(input logic [31:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		apbXfer(1'b1, addr, wdata, unused);
	endtask

	task automatic apbRead(input logic [31:0] addr, output logic [31:0] rdata);
		apbXfer(1'b0, addr, 32'h0, rdata);
	endtask

	function automatic instrT encR(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		instrT w;
		w = '0;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = shamt;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic instrT encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instrT w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm16 = imm;
		return w;
	endfunction

	function automatic instrT encJ(input logic [5:0] op, input logic [31:0] target);
		instrT w;
		w.j.op = op;
		w.j.target26 = target[27:2];
		return w;
	endfunction

	task automatic emit(input instrT w);
		prog.push_back(w);
	endtask

	task automatic loadImm(input logic [4:0] r, input logic [31:0] v);
		emit(encI(6'd15, 5'd0, r, v[31:16])); // LUI
		emit(encI(6'd13, r, r, v[15:0]));     // ORI
	endtask

	task automatic expectWord(input logic [31:0] addr, input logic [31:0] v);
		expAddr.push_back(addr);
		expVal.push_back(v);
	endtask

	// SW rt to the next result slot
	task automatic storeSlot(input logic [4:0] rt, input logic [31:0] v);
		emit(encI(6'd43, 5'd0, rt, slotAddr[15:0]));
		expectWord(slotAddr, v);
		slotAddr = slotAddr + 4;
	endtask

	task automatic newProgram(input logic [31:0] slotBase);
		prog.delete();
		expAddr.delete();
		expVal.delete();
		slotAddr = slotBase;
	endtask

	task automatic loadProgram();
		loopAddr = prog.size() * 4;
		emit(encJ(6'd2, loopAddr)); // Final self-loop
		foreach (prog[i])
			apbWrite(i * 4, prog[i]);
	endtask

	task automatic waitLoop();
		logic [31:0] pcv;
		do apbRead(`STAT_ADDR, pcv); while (pcv != loopAddr);
	endtask

	task automatic runProgram();
		apbWrite(`CTRL_ADDR, 32'd1);
		waitLoop();
		apbWrite(`CTRL_ADDR, 32'd0);
	endtask

	task automatic verifyResults(input string name);
		logic [31:0] v;
		foreach (expAddr[i]) begin
			apbRead(expAddr[i], v);
			check(v, expVal[i], $sformatf("%s word at %h", name, expAddr[i]));
		end
	endtask

	task automatic testResetAndMemory();
		logic [31:0] v, w;
		apbRead(`CTRL_ADDR, v);
		check(v, 32'h0, "control after reset");
		apbRead(`STAT_ADDR, v);
		check(v, 32'h0, "status after reset");
		for (int i = 0; i < 8; i++) begin
			w = lfsrWord();
			apbWrite(32'hC00 + i * 4, w);
			apbRead(32'hC00 + i * 4, v);
			check(v, w, "APB memory readback");
		end
	endtask

	task automatic aluR(input logic [5:0] funct, input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] shamt, input logic [31:0] exp);
		emit(encR(funct, rs, rt, 5'd3, shamt));
		storeSlot(5'd3, exp);
	endtask

	task automatic aluI(input logic [5:0] op, input logic [15:0] imm, input logic [31:0] exp);
		emit(encI(op, 5'd1, 5'd3, imm));
		storeSlot(5'd3, exp);
	endtask

	task automatic testAlu();
		logic [31:0] a, b, t, sx, zx;
		logic [15:0] imm;
		a = lfsrWord() | 32'h8000_0000; // Negative to exercise signed ops
		b = lfsrWord();
		t = lfsrWord();
		imm = t[15:0] | 16'h8000;
		sx = {{16{imm[15]}}, imm};
		zx = {16'h0000, imm};
		newProgram(32'h400);
		loadImm(5'd1, a);
		loadImm(5'd2, b);
		aluR(6'd32, 5'd1, 5'd2, 5'd0, a + b);
		aluR(6'd33, 5'd1, 5'd2, 5'd0, a + b);
		aluR(6'd34, 5'd1, 5'd2, 5'd0, a - b);
		aluR(6'd35, 5'd1, 5'd2, 5'd0, a - b);
		aluR(6'd36, 5'd1, 5'd2, 5'd0, a & b);
		aluR(6'd37, 5'd1, 5'd2, 5'd0, a | b);
		aluR(6'd38, 5'd1, 5'd2, 5'd0, a ^ b);
		aluR(6'd39, 5'd1, 5'd2, 5'd0, ~(a | b));
		aluR(6'd42, 5'd1, 5'd2, 5'd0, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		aluR(6'd43, 5'd1, 5'd2, 5'd0, (a < b) ? 32'd1 : 32'd0);
		aluR(6'd0, 5'd0, 5'd2, 5'd5, b << 5);
		aluR(6'd3, 5'd0, 5'd1, 5'd7, $signed(a) >>> 7);
		aluR(6'd4, 5'd1, 5'd2, 5'd0, b << a[4:0]);
		aluR(6'd7, 5'd2, 5'd1, 5'd0, $signed(a) >>> b[4:0]);
		aluI(6'd8, imm, a + sx);
		aluI(6'd9, imm, a + sx);
		aluI(6'd10, imm, ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0);
		aluI(6'd11, imm, (a < sx) ? 32'd1 : 32'd0);
		aluI(6'd12, imm, a & zx);
		aluI(6'd13, imm, a | zx);
		aluI(6'd14, imm, a ^ zx);
		emit(encI(6'd15, 5'd0, 5'd3, imm));
		storeSlot(5'd3, {imm, 16'h0000});
		loadProgram();
		runProgram();
		verifyResults("ALU");
	endtask

	task automatic loadCase(input logic [5:0] op, input logic [15:0] addr,
		input logic [31:0] exp);
		emit(encI(op, 5'd0, 5'd3, addr));
		storeSlot(5'd3, exp);
	endtask

	task automatic testByteLanes();
		logic [31:0] w0, w1, k, v;
		w0 = lfsrWord();
		w1 = lfsrWord();
		k = lfsrWord() | 32'h8080_8080; // Every byte negative
		v = lfsrWord();
		newProgram(32'h520);
		loadImm(5'd1, v);
		emit(encI(6'd40, 5'd0, 5'd1, 16'h0501)); // SB lane 1
		expectWord(32'h500, {w0[31:16], v[7:0], w0[7:0]});
		emit(encI(6'd41, 5'd0, 5'd1, 16'h0506)); // SH upper half
		expectWord(32'h504, {v[15:0], w1[15:0]});
		loadCase(6'd32, 16'h0513, {{24{k[31]}}, k[31:24]});
		loadCase(6'd36, 16'h0511, {24'h0, k[15:8]});
		loadCase(6'd33, 16'h0512, {{16{k[31]}}, k[31:16]});
		loadCase(6'd37, 16'h0510, {16'h0, k[15:0]});
		loadCase(6'd35, 16'h0510, k);
		apbWrite(32'h500, w0);
		apbWrite(32'h504, w1);
		apbWrite(32'h510, k);
		loadProgram();
		runProgram();
		verifyResults("Byte lane");
	endtask

	// Offset 1 skips the marker store when taken
	task automatic branchCase(input instrT br, input logic taken);
		emit(br);
		storeSlot(5'd5, taken ? 32'h0 : MARKER);
	endtask

	task automatic testBranches();
		logic [31:0] p;
		newProgram(32'h700);
		emit(encI(6'd13, 5'd0, 5'd5, MARKER[15:0]));
		emit(encI(6'd15, 5'd0, 5'd6, 16'h8000)); // Negative
		emit(encI(6'd13, 5'd0, 5'd7, 16'd5));    // Positive
		branchCase(encI(6'd4, 5'd7, 5'd7, 16'd1), 1'b1);
		branchCase(encI(6'd4, 5'd7, 5'd6, 16'd1), 1'b0);
		branchCase(encI(6'd5, 5'd7, 5'd6, 16'd1), 1'b1);
		branchCase(encI(6'd5, 5'd7, 5'd7, 16'd1), 1'b0);
		branchCase(encI(6'd1, 5'd6, 5'd0, 16'd1), 1'b1);
		branchCase(encI(6'd1, 5'd7, 5'd0, 16'd1), 1'b0);
		branchCase(encI(6'd1, 5'd7, 5'd1, 16'd1), 1'b1);
		branchCase(encI(6'd1, 5'd6, 5'd1, 16'd1), 1'b0);
		branchCase(encI(6'd1, 5'd0, 5'd1, 16'd1), 1'b1);
		branchCase(encI(6'd7, 5'd7, 5'd0, 16'd1), 1'b1);
		branchCase(encI(6'd7, 5'd0, 5'd0, 16'd1), 1'b0);
		branchCase(encI(6'd7, 5'd6, 5'd0, 16'd1), 1'b0);
		p = prog.size() * 4;
		emit(encJ(6'd2, p + 8));
		storeSlot(5'd5, 32'h0);
		p = prog.size() * 4;
		emit(encJ(6'd3, p + 8)); // JAL
		storeSlot(5'd5, 32'h0);
		storeSlot(5'd31, p + 4);
		p = (prog.size() + 2) * 4; // JR after the two-word load
		loadImm(5'd8, p + 8);
		emit(encR(6'd8, 5'd8, 5'd0, 5'd0, 5'd0));
		storeSlot(5'd5, 32'h0);
		storeSlot(5'd5, MARKER);
		foreach (expAddr[i])
			apbWrite(expAddr[i], 32'h0);
		loadProgram();
		runProgram();
		verifyResults("Branch");
	endtask

	task automatic buildStoreLoop();
		newProgram(32'h600);
		emit(encI(6'd13, 5'd0, 5'd1, 16'h0600));
		emit(encI(6'd13, 5'd0, 5'd2, 16'd16));
		emit(encI(6'd43, 5'd1, 5'd2, 16'h0000)); // Loop body
		emit(encI(6'd9, 5'd1, 5'd1, 16'd4));
		emit(encI(6'd9, 5'd2, 5'd2, 16'hFFFF));
		emit(encI(6'd5, 5'd2, 5'd0, 16'hFFFC));
		for (int k = 0; k < 16; k++)
			expectWord(32'h600 + k * 4, 32'd16 - k);
	endtask

	task automatic testSharedAccess();
		logic [31:0] pre, v;
		pre = lfsrWord();
		apbWrite(32'h900, pre);
		buildStoreLoop();
		loadProgram();
		apbWrite(`CTRL_ADDR, 32'd1);
		for (int i = 0; i < 4; i++) begin
			apbRead(32'h900, v);
			check(v, pre, "host read during run");
		end
		waitLoop();
		apbWrite(`CTRL_ADDR, 32'd0);
		verifyResults("Store loop");
	endtask

	task automatic testFreezeRestart();
		logic [31:0] s1, s2, v;
		apbWrite(`CTRL_ADDR, 32'd1);
		apbWrite(`CTRL_ADDR, 32'd0); // Stops inside the store loop
		apbRead(`STAT_ADDR, s1);
		repeat (10) @(posedge clk);
		apbRead(`STAT_ADDR, s2);
		check(s2, s1, "PC frozen while stopped");
		check({31'd0, s1 == loopAddr}, 32'd0, "PC stopped before the self-loop");
		apbWrite(32'h600, 32'h0);
		runProgram();
		apbRead(32'h600, v);
		check(v, 32'd16, "first store after restart");
	endtask

	initial begin
		apbReq = '0;
		lfsrState = 32'd93;
		loopAddr = '0;
		slotAddr = '0;
		wait (arstN === 1'b1);
		@(posedge clk);
		testResetAndMemory();
		testAlu();
		testByteLanes();
		testBranches();
		testSharedAccess();
		testFreezeRestart();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
src/cpuPkg.sv
src/ctrlDecoder.sv
src/aluUnit.sv
src/regFile.sv
src/cpuCore.sv
src/apbPort.sv
src/sharedMem.sv
src/mipsTop.sv
dv/tbClock.sv
dv/mipsTb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mipsTb -f vlog.f -o simv
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	exit 1
fi
if echo "$out" | grep -q "TESTS PASSED"; then
	exit 0
fi
exit 1
